// File: dv/exe_stage_tb.sv
// ********************
// execute stage testbench driving a table of entries back to back
// ********************
`timescale 1ns/100ps
`include "exe_defs.svh"

module exe_stage_tb;

    // one table row with its stimulus and the outputs it must produce
    typedef struct packed {
        logic                stall;
        logic                flush;
        exe_pkg::id_exe_s    id;
        exe_pkg::exe_mem_s   mem;
        logic                exc;
        logic [2:0]          cause;
        logic                miss;
        exe_pkg::word_t      target;
    } entry_s;

    logic              clk;
    logic              i_rst_n;
    logic              i_stall;
    logic              i_flush;
    exe_pkg::id_exe_s  i_id;
    exe_pkg::exe_mem_s o_mem;
    logic              o_exc;
    logic [2:0]        o_cause;
    logic              o_bp_miss;
    exe_pkg::word_t    o_br_target;

    entry_s tbl[$];
    string  names[$];
    integer seed = 32'h29d1;
    logic   built = 1'b0;

    exe_stage_top exe_stage_top_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (i_stall),
        .i_flush     (i_flush),
        .i_id        (i_id),
        .o_mem       (o_mem),
        .o_exc       (o_exc),
        .o_cause     (o_cause),
        .o_bp_miss   (o_bp_miss),
        .o_br_target (o_br_target)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "exe_stage_tb stopped on first error");
    endtask

    task automatic check_word(input string name, input exe_pkg::word_t exp,
                              input exe_pkg::word_t act);
        if (act !== exp)
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_mem(input string name, input exe_pkg::exe_mem_s exp,
                             input exe_pkg::exe_mem_s act);
        // alu result checked ahead of the whole record
        check_word({name, " alu_out"}, exp.alu_out, act.alu_out);
        if (act !== exp)
            abort_run($sformatf("MISMATCH %s o_mem expected %h actual %h", name, exp, act));
    endtask

    task automatic check_exc(input string name, input logic exp_exc, input logic [2:0] exp_cause,
                             input logic act_exc, input logic [2:0] act_cause);
        if ({act_exc, act_cause} !== {exp_exc, exp_cause})
            abort_run($sformatf("MISMATCH %s exc/cause expected %b/%0d actual %b/%0d",
                                name, exp_exc, exp_cause, act_exc, act_cause));
    endtask

    task automatic check_branch(input string name, input logic exp_miss,
                                input exe_pkg::word_t exp_target,
                                input logic act_miss, input exe_pkg::word_t act_target);
        if (act_miss !== exp_miss)
            abort_run($sformatf("MISMATCH %s bp_miss expected %b actual %b",
                                name, exp_miss, act_miss));
        check_word({name, " br_target"}, exp_target, act_target);
    endtask

    function automatic exe_pkg::word_t rnd();
        return $random(seed);
    endfunction

    // random instruction with no branch, no trap and a plain add
    function automatic exe_pkg::id_exe_s rand_id();
        exe_pkg::id_exe_s id;
        exe_pkg::word_t   w;
        id = '0;
        id.da = rnd();
        id.db = rnd();
        id.imm = rnd();
        id.ins = rnd();
        id.epc = rnd();
        id.bpc = rnd();
        w = rnd();
        id.pc = {w[31:2], 2'b00};
        w = rnd();
        id.target_reg = w[4:0];
        id.mem_to_reg = w[5];
        id.mem_req = w[6];
        id.mem_write = w[7];
        id.reg_write = 1'b1;
        id.alu_func = exe_pkg::ALU_ADD;
        id.br_kind = exe_pkg::BR_NONE;
        id.no_br_pc = id.pc + 32'd4;
        id.predicted_pc = id.no_br_pc;
        return id;
    endfunction

    // where the branch really goes
    function automatic exe_pkg::word_t resolve_target(input exe_pkg::id_exe_s id);
        logic taken;
        taken = 1'b0;
        case (id.br_kind)
            exe_pkg::BR_J, exe_pkg::BR_JAL: return {id.pc[31:28], id.ins.j_fmt.index, 2'b00};
            exe_pkg::BR_JR, exe_pkg::BR_JALR: return id.da;
            exe_pkg::BR_ERET: return id.epc;
            exe_pkg::BR_BGEZ, exe_pkg::BR_BGEZAL: taken = $signed(id.da) >= 0;
            exe_pkg::BR_BLTZ, exe_pkg::BR_BLTZAL: taken = $signed(id.da) < 0;
            exe_pkg::BR_BLEZ: taken = $signed(id.da) <= 0;
            exe_pkg::BR_BGTZ: taken = $signed(id.da) > 0;
            exe_pkg::BR_BEQ: taken = id.da == id.db;
            exe_pkg::BR_BNE: taken = id.da != id.db;
            default: taken = 1'b0;
        endcase
        return taken ? id.bpc : id.no_br_pc;
    endfunction

    // works out the expected record and appends the row
    task automatic add_entry(input string name, input logic stall,
                             input exe_pkg::id_exe_s id, input logic flush);
        entry_s         e;
        exe_pkg::word_t a;
        exe_pkg::word_t b;
        exe_pkg::word_t r;
        logic [32:0]    wide;
        logic           ovf;
        logic           cancel;
        a = id.shift_imm ? {27'd0, id.ins.r_fmt.shamt} : id.da;
        b = id.alu_imm ? id.imm : id.db;
        ovf = 1'b0;
        wide = '0;
        case (id.alu_func)
            exe_pkg::ALU_ADD: begin
                wide = {a[31], a} + {b[31], b};
                r = wide[31:0];
                // sign-extended sum disagrees with its own sign bit
                ovf = wide[32] ^ wide[31];
            end
            exe_pkg::ALU_SUB: begin
                wide = {a[31], a} - {b[31], b};
                r = wide[31:0];
                ovf = wide[32] ^ wide[31];
            end
            exe_pkg::ALU_AND: r = a & b;
            exe_pkg::ALU_OR:  r = a | b;
            exe_pkg::ALU_XOR: r = a ^ b;
            exe_pkg::ALU_NOR: r = ~(a | b);
            exe_pkg::ALU_SLL: r = b << a[4:0];
            exe_pkg::ALU_SRL: r = b >> a[4:0];
            exe_pkg::ALU_SRA: r = exe_pkg::word_t'($signed(b) >>> a[4:0]);
            exe_pkg::ALU_LUI: r = {b[15:0], 16'h0000};
            default: r = '0;
        endcase
        if (id.link)
            r = id.pc + 32'd4;
        else if (id.slt)
            r = {31'd0, id.slt_sign ? ($signed(a) < $signed(b)) : (a < b)};
        cancel = id.canceled | flush;
        e = '0;
        e.stall = stall;
        e.flush = flush;
        e.id = id;
        e.mem.canceled = cancel;
        e.mem.pc = id.pc;
        e.mem.alu_out = r;
        e.mem.db = id.db;
        e.mem.target_reg = id.link ? `EXE_LINK_REG : id.target_reg;
        e.mem.reg_write = id.reg_write;
        e.mem.mem_to_reg = id.mem_to_reg;
        e.mem.mem_req = id.mem_req;
        e.mem.mem_write = id.mem_write;
        e.target = resolve_target(id);
        e.exc = !cancel && id.trap_ovf && ovf;
        e.cause = e.exc ? `EXE_CAUSE_OVF : `EXE_CAUSE_NONE;
        e.miss = !cancel && (id.br_kind != exe_pkg::BR_NONE) && (id.predicted_pc != e.target);
        tbl.push_back(e);
        names.push_back(name);
    endtask

    task automatic build_table();
        exe_pkg::id_exe_s id;
        exe_pkg::word_t   tgt;
        int               i;
        int               k;
        int               p;
        // every alu op with the odd ones on the immediate and two shifts on shamt
        for (i = 0; i < 10; i++) begin
            id = rand_id();
            id.alu_func = exe_pkg::alu_func_e'(i);
            id.alu_imm = i[0];
            id.shift_imm = (i == 6 || i == 8);
            // shift by a nonzero shamt
            if (id.shift_imm)
                id.ins.r_fmt.shamt[0] = 1'b1;
            // negative b keeps sra apart from srl
            if (i == 8)
                id.db[31] = 1'b1;
            add_entry($sformatf("alu_func_%0d", i), 1'b0, id, 1'b0);
        end
        // -16 against 16 splits signed from unsigned
        for (i = 0; i < 2; i++) begin
            id = rand_id();
            id.slt = 1'b1;
            id.slt_sign = i[0];
            id.da = 32'hffff_fff0;
            id.db = 32'h0000_0010;
            add_entry($sformatf("slt_sign_%0d", i), 1'b0, id, 1'b0);
        end
        // random i_id under stall must never be captured
        for (i = 0; i < 3; i++)
            add_entry("stall", 1'b1, rand_id(), 1'b0);
        // each branch kind predicted right (p=1) and wrong (p=0)
        for (k = 1; k < 14; k++) begin
            for (p = 0; p < 2; p++) begin
                id = rand_id();
                id.br_kind = exe_pkg::br_kind_e'(k);
                id.link = (k == 2 || k == 4 || k == 7 || k == 9);
                if (p == 1 && (k == 12 || k == 13))
                    id.db = id.da;
                if (p == 1 && (k == 10 || k == 11))
                    id.da = '0;
                tgt = resolve_target(id);
                id.predicted_pc = (p == 1) ? tgt : tgt + 32'd8;
                add_entry($sformatf("br_kind_%0d_hit_%0d", k, p), 1'b0, id, 1'b0);
            end
        end
        // max positive plus one
        id = rand_id();
        id.da = 32'h7fff_ffff;
        id.db = 32'h0000_0001;
        id.trap_ovf = 1'b1;
        add_entry("add_ovf_trap", 1'b0, id, 1'b0);
        add_entry("flushed_ovf", 1'b0, id, 1'b1);
        id.canceled = 1'b1;
        add_entry("canceled_ovf", 1'b0, id, 1'b0);
        id.canceled = 1'b0;
        id.trap_ovf = 1'b0;
        add_entry("add_ovf_quiet", 1'b0, id, 1'b0);
        // most negative minus one
        id.alu_func = exe_pkg::ALU_SUB;
        id.da = 32'h8000_0000;
        id.trap_ovf = 1'b1;
        add_entry("sub_ovf_trap", 1'b0, id, 1'b0);
        // jump that fetched the wrong address but is flushed
        id = rand_id();
        id.br_kind = exe_pkg::BR_J;
        id.predicted_pc = resolve_target(id) + 32'd8;
        add_entry("flushed_miss", 1'b0, id, 1'b1);
        // flush stays up across the stall and lands afterward
        add_entry("stall", 1'b1, rand_id(), 1'b0);
        add_entry("stall", 1'b1, rand_id(), 1'b0);
        id.canceled = 1'b1;
        add_entry("canceled_miss", 1'b0, id, 1'b0);
        add_entry("tail_add", 1'b0, rand_id(), 1'b0);
    endtask

    // compares the stage outputs with the row now in exe/mem
    task automatic check_slot(input int idx);
        entry_s e;
        string  name;
        if (idx < 0) begin
            // reset or bubble leaves everything zero
            e = '0;
            name = "idle";
        end else begin
            e = tbl[idx];
            name = names[idx];
        end
        check_mem(name, e.mem, o_mem);
        check_exc(name, e.exc, e.cause, o_exc, o_cause);
        check_branch(name, e.miss, e.target, o_bp_miss, o_br_target);
    endtask

    initial begin
        exe_pkg::id_exe_s rst_id;
        int t;
        int ex_idx;
        int mem_idx;
        i_rst_n = 1'b0;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_id = '0;
        build_table();
        built = 1'b1;
        // overflowing mispredicted store held on the input during reset
        rst_id = rand_id();
        rst_id.mem_req = 1'b1;
        rst_id.trap_ovf = 1'b1;
        rst_id.da = 32'h7fff_ffff;
        rst_id.db = 32'h0000_0001;
        rst_id.br_kind = exe_pkg::BR_JR;
        rst_id.predicted_pc = rst_id.da + 32'd8;
        i_id = rst_id;
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        ex_idx = -1;
        mem_idx = -1;
        // two extra bubble cycles drain the pipe
        for (t = 0; t < tbl.size() + 2; t++) begin
            check_slot(mem_idx);
            if (t < tbl.size()) begin
                i_stall = tbl[t].stall;
                i_id = tbl[t].id;
            end else begin
                i_stall = 1'b0;
                i_id = '0;
            end
            // flush targets whatever sits in exe this cycle
            i_flush = (ex_idx >= 0) ? tbl[ex_idx].flush : 1'b0;
            @(posedge clk);
            if (!i_stall) begin
                mem_idx = ex_idx;
                ex_idx = (t < tbl.size()) ? t : -1;
            end
            @(negedge clk);
        end
        check_slot(mem_idx);
        $display("sim passed");
        $finish;
    end

    // ten cycles per row plus margin for reset and drain
    initial begin
        wait (built === 1'b1);
        repeat (tbl.size() * 10 + 100) @(posedge clk);
        $display("timeout: the table did not finish within %0d cycles", tbl.size() * 10 + 100);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: hw/alu_path.sv
// ********************
// exe alu path: operand select, alu, slt, link result, overflow
// ********************
`timescale 1ns/100ps
`include "exe_defs.svh"

module alu_path (
    input  exe_pkg::id_exe_s  i_ex,
    output exe_pkg::alu_out_s o_alu
);

    localparam int MSB  = `EXE_XLEN - 1;
    localparam int SH_W = $clog2(`EXE_XLEN);

    exe_pkg::word_t op_a;
    exe_pkg::word_t op_b;
    exe_pkg::word_t sum;
    exe_pkg::word_t diff;
    exe_pkg::word_t alu_res;
    logic [SH_W-1:0] sh_amt;
    logic add_ovf;
    logic sub_ovf;
    logic alu_ovf;
    logic lt_s;
    logic lt_u;

    // operand a: immediate shift amount or rs
    assign op_a = i_ex.shift_imm ? exe_pkg::word_t'(i_ex.ins.r_fmt.shamt) : i_ex.da;
    // operand b: immediate or rt
    assign op_b = i_ex.alu_imm ? i_ex.imm : i_ex.db;

    // shifts use the low bits of a on b
    assign sh_amt = op_a[SH_W-1:0];

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // signed overflow from sign bits
    // add: same-sign operands giving a result of the other sign
    assign add_ovf = (op_a[MSB] == op_b[MSB]) && (sum[MSB] != op_a[MSB]);
    // sub: differing signs, result sign flips away from a
    assign sub_ovf = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);

    // set-less-than compares, both flavours always computed
    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    // alu proper
    always_comb begin
        alu_res = sum;
        alu_ovf = 1'b0;
        case (i_ex.alu_func)
            exe_pkg::ALU_ADD: begin
                alu_res = sum;
                alu_ovf = add_ovf;
            end
            exe_pkg::ALU_SUB: begin
                alu_res = diff;
                alu_ovf = sub_ovf;
            end
            exe_pkg::ALU_AND: alu_res = op_a & op_b;
            exe_pkg::ALU_OR:  alu_res = op_a | op_b;
            exe_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            exe_pkg::ALU_NOR: alu_res = ~(op_a | op_b);
            exe_pkg::ALU_SLL: alu_res = op_b << sh_amt;
            exe_pkg::ALU_SRL: alu_res = op_b >> sh_amt;
            // arithmetic shift keeps the sign of b
            exe_pkg::ALU_SRA: alu_res = exe_pkg::word_t'($signed(op_b) >>> sh_amt);
            // load upper immediate
            exe_pkg::ALU_LUI: alu_res = op_b << 16;
            default: begin
                alu_res = sum;
                alu_ovf = 1'b0;
            end
        endcase
    end

    // output mux, link wins over slt, slt over the alu
    always_comb begin
        if (i_ex.link) begin
            // return address, no delay slot
            o_alu.result = i_ex.pc + exe_pkg::word_t'(4);
        end else if (i_ex.slt) begin
            o_alu.result = exe_pkg::word_t'(i_ex.slt_sign ? lt_s : lt_u);
        end else begin
            o_alu.result = alu_res;
        end
    end

    // jump-and-link always writes the link register
    assign o_alu.target_reg = i_ex.link ? `EXE_LINK_REG : i_ex.target_reg;

    // only add and sub can overflow
    assign o_alu.overflow = alu_ovf;

endmodule

// File: hw/branch_resolve.sv
// ********************
// branch condition, target select and mispredict compare
// ********************
`timescale 1ns/100ps

module branch_resolve (
    input  exe_pkg::id_exe_s i_ex,
    output exe_pkg::br_out_s o_br
);

    exe_pkg::word_t jpc;
    exe_pkg::word_t target;
    logic rs_zero;
    logic rs_neg;
    logic rs_rt_eq;
    logic taken;

    // j/jal target, upper bits come from the branch's own pc
    assign jpc = {i_ex.pc[31:28], i_ex.ins.j_fmt.index, 2'b00};

    // condition flags on rs (and rt for beq/bne)
    assign rs_zero  = (i_ex.da == '0);
    assign rs_neg   = i_ex.da[31];
    assign rs_rt_eq = (i_ex.da == i_ex.db);

    always_comb begin
        // decode must only hand over defined branch kinds
        assert (i_ex.br_kind <= exe_pkg::BR_BNE || $isunknown(i_ex.br_kind))
            else $error("branch_resolve: illegal br_kind %0d", i_ex.br_kind);

        taken  = 1'b0;
        target = i_ex.no_br_pc;
        case (i_ex.br_kind)
            exe_pkg::BR_J, exe_pkg::BR_JAL: begin
                target = jpc;
            end
            exe_pkg::BR_JR, exe_pkg::BR_JALR: begin
                // register jump
                target = i_ex.da;
            end
            exe_pkg::BR_ERET: begin
                target = i_ex.epc;
            end
            exe_pkg::BR_BGEZ, exe_pkg::BR_BGEZAL: taken = !rs_neg;
            exe_pkg::BR_BLTZ, exe_pkg::BR_BLTZAL: taken = rs_neg;
            exe_pkg::BR_BLEZ: taken = rs_neg || rs_zero;
            exe_pkg::BR_BGTZ: taken = !rs_neg && !rs_zero;
            exe_pkg::BR_BEQ:  taken = rs_rt_eq;
            exe_pkg::BR_BNE:  taken = !rs_rt_eq;
            default: begin
                // not a branch, fall through
                taken  = 1'b0;
                target = i_ex.no_br_pc;
            end
        endcase

        // conditional branch that holds goes to bpc
        if (taken) begin
            target = i_ex.bpc;
        end
    end

    assign o_br.is_branch = (i_ex.br_kind != exe_pkg::BR_NONE);
    assign o_br.br_target = target;
    // fetch went somewhere other than where the branch resolved
    assign o_br.miss = o_br.is_branch && (i_ex.predicted_pc != target);

endmodule

// File: hw/exe_commit.sv
// ********************
// exe/mem register with cancel, overflow exception and mispredict
// ********************
`timescale 1ns/100ps
`include "exe_defs.svh"

module exe_commit (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_stall,
    input  logic              i_flush,
    input  exe_pkg::id_exe_s  i_ex,
    input  exe_pkg::alu_out_s i_alu,
    input  exe_pkg::br_out_s  i_br,
    output exe_pkg::exe_mem_s o_mem,
    output logic              o_exc,
    output logic [2:0]        o_cause,
    output logic              o_bp_miss,
    output exe_pkg::word_t    o_br_target
);

    exe_pkg::exe_mem_s mem_d;
    logic cancel_now;
    logic exc_now;
    logic miss_now;

    // canceled upstream or flushed while sitting in exe
    assign cancel_now = i_ex.canceled || i_flush;

    // overflow traps only when the instruction asks for it
    assign exc_now  = !cancel_now && i_ex.trap_ovf && i_alu.overflow;
    // a dead instruction never redirects fetch
    assign miss_now = !cancel_now && i_br.miss;

    // next exe/mem record
    always_comb begin
        mem_d            = '0;
        mem_d.canceled   = cancel_now;
        mem_d.pc         = i_ex.pc;
        mem_d.alu_out    = i_alu.result;
        // store data
        mem_d.db         = i_ex.db;
        mem_d.target_reg = i_alu.target_reg;
        mem_d.reg_write  = i_ex.reg_write;
        mem_d.mem_to_reg = i_ex.mem_to_reg;
        mem_d.mem_req    = i_ex.mem_req;
        mem_d.mem_write  = i_ex.mem_write;
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_mem       <= '0;
            o_exc       <= 1'b0;
            o_cause     <= `EXE_CAUSE_NONE;
            o_bp_miss   <= 1'b0;
            o_br_target <= '0;
        end else if (!i_stall) begin
            o_mem       <= mem_d;
            o_exc       <= exc_now;
            o_cause     <= exc_now ? `EXE_CAUSE_OVF : `EXE_CAUSE_NONE;
            o_bp_miss   <= miss_now;
            o_br_target <= i_br.br_target;
        end
    end

    // exception must never come from a canceled slot
    a_exc_live : assert property (@(posedge clk) disable iff (!i_rst_n)
        o_exc |-> !o_mem.canceled)
        else $error("exe_commit: exception raised on a canceled record");

    // cause and flag travel together
    a_cause_match : assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_cause != `EXE_CAUSE_NONE) == o_exc)
        else $error("exe_commit: o_cause %0d disagrees with o_exc", o_cause);

endmodule

// File: hw/exe_defs.svh
// ********************
// execute stage widths, register indices and exception cause codes
// ********************
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// data and address width
`define EXE_XLEN 32

// register written by jal, jalr and the linking conditional branches
`define EXE_LINK_REG 5'd31

// shift-amount field inside the instruction word
`define EXE_SHAMT_LSB 6
`define EXE_SHAMT_MSB 10

// exception cause codes, 3 bits wide
// none means no exception in this stage
`define EXE_CAUSE_NONE 3'd0
// signed add/sub overflow
`define EXE_CAUSE_OVF 3'd1

`endif

// File: hw/exe_input_reg.sv
// ********************
// id/exe pipeline register, holds while stalled
// ********************
`timescale 1ns/100ps

module exe_input_reg (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_stall,
    input  exe_pkg::id_exe_s i_id,
    output exe_pkg::id_exe_s o_ex
);

    // whole decoded record moves in one step
    // reset clears every control bit, so a bubble leaves the stage idle
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_ex <= '0;
        end else if (!i_stall) begin
            o_ex <= i_id;
        end
    end

    // stall must freeze the instruction in exe for the whole cycle
    // otherwise the commit register would capture a different record
    // than the one it held back
    property p_stall_hold;
        @(posedge clk) disable iff (!i_rst_n)
            i_stall |=> $stable(o_ex);
    endproperty

    a_stall_hold : assert property (p_stall_hold)
        else $error("exe_input_reg: o_ex changed across a stalled edge");

endmodule

// File: hw/exe_pkg.sv
// ********************
// execute stage types: instruction views, enums and stage records
// ********************
`include "exe_defs.svh"

package exe_pkg;

    // basic scalars
    typedef logic [`EXE_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // alu operation selected by decode
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_SRA = 4'd8,
        ALU_LUI = 4'd9
    } alu_func_e;

    // branch kind, replaces the one-hot branch flags of the decoder
    // codes 14 and 15 are unused
    typedef enum logic [3:0] {
        BR_NONE   = 4'd0,
        BR_J      = 4'd1,
        BR_JAL    = 4'd2,
        BR_JR     = 4'd3,
        BR_JALR   = 4'd4,
        BR_ERET   = 4'd5,
        BR_BGEZ   = 4'd6,
        BR_BGEZAL = 4'd7,
        BR_BLTZ   = 4'd8,
        BR_BLTZAL = 4'd9,
        BR_BLEZ   = 4'd10,
        BR_BGTZ   = 4'd11,
        BR_BEQ    = 4'd12,
        BR_BNE    = 4'd13
    } br_kind_e;

    // jump format view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_fmt_s;

    // register format view, shamt sits at bits 10..6
    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [`EXE_SHAMT_MSB-`EXE_SHAMT_LSB:0] shamt;
        logic [5:0] funct;
    } r_fmt_s;

    // one instruction word, decoded either way
    typedef union packed {
        j_fmt_s j_fmt;
        r_fmt_s r_fmt;
    } instr_u;

    // decoded instruction entering exe
    typedef struct packed {
        logic      canceled;
        word_t     pc;
        instr_u    ins;
        word_t     da;
        word_t     db;
        word_t     imm;
        reg_idx_t  target_reg;
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_req;
        logic      mem_write;
        logic      alu_imm;
        logic      shift_imm;
        logic      link;
        logic      slt;
        logic      slt_sign;
        logic      trap_ovf;
        alu_func_e alu_func;
        br_kind_e  br_kind;
        word_t     epc;
        // taken target
        word_t     bpc;
        // fall-through target
        word_t     no_br_pc;
        // address fetched right after this instruction
        word_t     predicted_pc;
    } id_exe_s;

    // alu path results
    typedef struct packed {
        word_t    result;
        reg_idx_t target_reg;
        logic     overflow;
    } alu_out_s;

    // branch resolver results
    typedef struct packed {
        logic  is_branch;
        word_t br_target;
        logic  miss;
    } br_out_s;

    // exe/mem pipeline register contents
    typedef struct packed {
        logic     canceled;
        word_t    pc;
        word_t    alu_out;
        word_t    db;
        reg_idx_t target_reg;
        logic     reg_write;
        logic     mem_to_reg;
        logic     mem_req;
        logic     mem_write;
    } exe_mem_s;

endpackage

// File: hw/exe_stage_top.sv
// ********************
// execute stage top: id/exe register, alu and branch units, exe/mem register
// ********************
`timescale 1ns/100ps

module exe_stage_top (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_stall,
    input  logic              i_flush,
    input  exe_pkg::id_exe_s  i_id,
    output exe_pkg::exe_mem_s o_mem,
    output logic              o_exc,
    output logic [2:0]        o_cause,
    output logic              o_bp_miss,
    output exe_pkg::word_t    o_br_target
);

    // instruction currently in exe
    exe_pkg::id_exe_s  ex;
    exe_pkg::alu_out_s alu;
    exe_pkg::br_out_s  br;

    exe_input_reg exe_input_reg_i (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_stall (i_stall),
        .i_id    (i_id),
        .o_ex    (ex)
    );

    // alu path and branch resolver run side by side on the same record
    alu_path alu_path_i (
        .i_ex  (ex),
        .o_alu (alu)
    );

    branch_resolve branch_resolve_i (
        .i_ex (ex),
        .o_br (br)
    );

    exe_commit exe_commit_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (i_stall),
        .i_flush     (i_flush),
        .i_ex        (ex),
        .i_alu       (alu),
        .i_br        (br),
        .o_mem       (o_mem),
        .o_exc       (o_exc),
        .o_cause     (o_cause),
        .o_bp_miss   (o_bp_miss),
        .o_br_target (o_br_target)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module exe_stage_tb -Mdir obj_dir

# the log decides the outcome, so a nonzero exit here must not stop the script
./obj_dir/Vexe_stage_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// File: sources.f
+incdir+hw
hw/exe_pkg.sv
hw/exe_input_reg.sv
hw/alu_path.sv
hw/branch_resolve.sv
hw/exe_commit.sv
hw/exe_stage_top.sv
dv/exe_stage_tb.sv
